/* logic/eth_tx_pkg.sv */
package eth_tx_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t;

    // First byte on the wire sits in bits 31:24
    typedef logic [31:0] crc_t;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_sfd,
        tx_payload,
        tx_pad,
        tx_fcs
    } tx_source_t;

    typedef struct packed {
        tx_source_t source;
        logic [1:0] fcs_index;
    } tx_command_t;

    typedef struct packed {
        byte_t data;
        logic  enable;
    } tx_lane_t;

    ////////////////////////////////////////////////////////////////////
    // Framing constants
    ////////////////////////////////////////////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_COUNT = 7;
    localparam int MIN_PAYLOAD    = 60;
    localparam int GAP_CYCLES     = 12;

endpackage

/* logic/frame_check_sequence_generator.sv */
`timescale 1ns/1ps

module frame_check_sequence_generator (
    input  logic              clock,
    input  logic              reset_n,
    input  eth_tx_pkg::byte_t data,
    input  logic              data_enable,
    input  logic              data_last,
    output logic              ready,
    output logic              checksum_valid,
    output eth_tx_pkg::crc_t  checksum
);

    typedef enum logic {
        st_calculate,
        st_finish
    } state_t;

    localparam eth_tx_pkg::crc_t CRC_POLYNOMIAL = 32'h04C1_1DB7;

    state_t            state;
    eth_tx_pkg::crc_t  lfsr;
    eth_tx_pkg::byte_t data_reflected;
    eth_tx_pkg::crc_t  lfsr_reflected;
    eth_tx_pkg::crc_t  checksum_next;

    // Advance the register by one octet, most significant bit of the
    // reflected byte first; the loop flattens into the parallel equations
    function automatic eth_tx_pkg::crc_t crc_step(
        input eth_tx_pkg::crc_t  crc,
        input eth_tx_pkg::byte_t octet
    );
        eth_tx_pkg::crc_t result;
        logic             feedback;
        result = crc;
        for (int i = 7; i >= 0; i--) begin
            feedback = result[31] ^ octet[i];
            result   = {result[30:0], 1'b0};
            if (feedback) begin
                result = result ^ CRC_POLYNOMIAL;
            end
        end
        return result;
    endfunction

    assign data_reflected = {<<{data}};
    assign lfsr_reflected = {<<{~lfsr}};

    // Byte order as sent on the wire
    assign checksum_next = {lfsr_reflected[7:0],   lfsr_reflected[15:8],
                            lfsr_reflected[23:16], lfsr_reflected[31:24]};

    ////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= st_calculate;
            lfsr           <= '1;
            ready          <= 1'b1;
            checksum       <= '0;
            checksum_valid <= 1'b0;
        end else begin
            checksum       <= checksum_next;
            checksum_valid <= 1'b0;
            case (state)
                st_calculate: begin
                    if (data_enable) begin
                        lfsr  <= crc_step(lfsr, data_reflected);
                        ready <= 1'b0;
                    end
                    if (data_last) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    // Result leaves this cycle, then reseed for the next frame
                    checksum_valid <= 1'b1;
                    lfsr           <= '1;
                    ready          <= 1'b1;
                    state          <= st_calculate;
                end
                default: begin
                    state <= st_calculate;
                end
            endcase
        end
    end

endmodule

/* logic/eth_tx_control.sv */
`timescale 1ns/1ps

module eth_tx_control #(
    parameter int BUFFER_DEPTH = 2048
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  eth_tx_pkg::byte_t       data,
    input  logic                    data_enable,
    input  logic                    data_last,
    output logic                    ready,
    output logic                    write_enable,
    output logic                    frame_start,
    output logic                    read_enable,
    output eth_tx_pkg::byte_t       crc_data,
    output logic                    crc_enable,
    output logic                    crc_last,
    input  logic                    checksum_valid,
    output logic                    fcs_load,
    output eth_tx_pkg::tx_command_t command
);

    localparam int COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef enum logic [3:0] {
        st_accept,
        st_pad,
        st_wait_fcs,
        st_preamble,
        st_sfd,
        st_payload,
        st_pad_out,
        st_fcs,
        st_gap
    } state_t;

    state_t state;
    count_t payload_count;
    count_t pad_length;
    // Shared by pad, preamble, payload, FCS and gap phases
    count_t phase_count;
    count_t next_count;
    logic   short_frame;
    logic   payload_done;
    logic   pad_done;
    logic   preamble_done;
    logic   fcs_done;
    logic   gap_done;

    assign next_count    = payload_count + 1'b1;
    assign short_frame   = next_count < count_t'(eth_tx_pkg::MIN_PAYLOAD);
    assign payload_done  = phase_count == payload_count - 1'b1;
    assign pad_done      = phase_count == pad_length - 1'b1;
    assign preamble_done = phase_count == count_t'(eth_tx_pkg::PREAMBLE_COUNT - 1);
    assign fcs_done      = phase_count == count_t'(3);
    // Extra cycle covers the output register delay
    assign gap_done      = phase_count == count_t'(eth_tx_pkg::GAP_CYCLES);

    ////////////////////////////////////////////////////////////////////
    // Strobes and wire command
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        ready             = 1'b0;
        write_enable      = 1'b0;
        frame_start       = 1'b0;
        read_enable       = 1'b0;
        crc_data          = '0;
        crc_enable        = 1'b0;
        crc_last          = 1'b0;
        fcs_load          = 1'b0;
        command.source    = eth_tx_pkg::tx_idle;
        command.fcs_index = 2'b00;
        case (state)
            st_accept: begin
                ready = 1'b1;
                if (data_enable) begin
                    write_enable = 1'b1;
                    crc_data     = data;
                    crc_enable   = 1'b1;
                    crc_last     = data_last && !short_frame;
                end
            end
            st_pad: begin
                crc_enable = 1'b1;
                crc_last   = pad_done;
            end
            st_wait_fcs: fcs_load = checksum_valid;
            st_preamble: command.source = eth_tx_pkg::tx_preamble;
            st_sfd: begin
                command.source = eth_tx_pkg::tx_sfd;
                read_enable    = 1'b1;
            end
            st_payload: begin
                command.source = eth_tx_pkg::tx_payload;
                // Last byte was already requested one cycle earlier
                read_enable    = !payload_done;
            end
            st_pad_out: command.source = eth_tx_pkg::tx_pad;
            st_fcs: begin
                command.source    = eth_tx_pkg::tx_fcs;
                command.fcs_index = phase_count[1:0];
            end
            st_gap: frame_start = gap_done;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state         <= st_accept;
            payload_count <= '0;
            pad_length    <= '0;
            phase_count   <= '0;
        end else begin
            case (state)
                st_accept: begin
                    if (data_enable) begin
                        payload_count <= next_count;
                        if (data_last) begin
                            phase_count <= '0;
                            if (short_frame) begin
                                pad_length <= count_t'(eth_tx_pkg::MIN_PAYLOAD) - next_count;
                                state      <= st_pad;
                            end else begin
                                pad_length <= '0;
                                state      <= st_wait_fcs;
                            end
                        end
                    end
                end
                st_pad: begin
                    if (pad_done) begin
                        phase_count <= '0;
                        state       <= st_wait_fcs;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                st_wait_fcs: begin
                    if (checksum_valid) begin
                        state <= st_preamble;
                    end
                end
                st_preamble: begin
                    if (preamble_done) begin
                        phase_count <= '0;
                        state       <= st_sfd;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                st_sfd: state <= st_payload;
                st_payload: begin
                    if (payload_done) begin
                        phase_count <= '0;
                        state       <= (pad_length != '0) ? st_pad_out : st_fcs;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                st_pad_out: begin
                    if (pad_done) begin
                        phase_count <= '0;
                        state       <= st_fcs;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                st_fcs: begin
                    if (fcs_done) begin
                        phase_count <= '0;
                        state       <= st_gap;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                st_gap: begin
                    if (gap_done) begin
                        phase_count   <= '0;
                        payload_count <= '0;
                        state         <= st_accept;
                    end else begin
                        phase_count <= phase_count + 1'b1;
                    end
                end
                default: state <= st_accept;
            endcase
        end
    end

    // Generator result only while the FSM waits for it
    checksum_in_wait : assert property (@(posedge clock) disable iff (!reset_n)
        checksum_valid |-> state == st_wait_fcs);

    no_buffer_overflow : assert property (@(posedge clock) disable iff (!reset_n)
        write_enable |-> payload_count < count_t'(BUFFER_DEPTH));

endmodule

/* logic/eth_tx_frame_buffer.sv */
`timescale 1ns/1ps

module eth_tx_frame_buffer #(
    parameter int BUFFER_DEPTH = 2048
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              frame_start,
    input  logic              write_enable,
    input  eth_tx_pkg::byte_t write_data,
    input  logic              read_enable,
    output eth_tx_pkg::byte_t read_data
);

    localparam int ADDRESS_WIDTH = $clog2(BUFFER_DEPTH);

    // One spare bit so a full frame does not wrap to zero
    typedef logic [ADDRESS_WIDTH:0] pointer_t;

    eth_tx_pkg::byte_t memory [BUFFER_DEPTH];
    pointer_t          write_pointer;
    pointer_t          read_pointer;

    always_ff @(posedge clock) begin
        if (!reset_n || frame_start) begin
            write_pointer <= '0;
            read_pointer  <= '0;
        end else begin
            if (write_enable) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (read_enable) begin
                read_pointer <= read_pointer + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_pointer[ADDRESS_WIDTH-1:0]] <= write_data;
        end
    end

    // Registered read port, data one cycle after the request
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= memory[read_pointer[ADDRESS_WIDTH-1:0]];
        end
    end

    read_behind_write : assert property (@(posedge clock) disable iff (!reset_n)
        read_enable |-> read_pointer < write_pointer);

endmodule

/* logic/eth_tx_output_stage.sv */
`timescale 1ns/1ps

module eth_tx_output_stage (
    input  logic                    clock,
    input  logic                    reset_n,
    input  eth_tx_pkg::tx_command_t command,
    input  eth_tx_pkg::byte_t       payload_byte,
    input  eth_tx_pkg::crc_t        checksum,
    input  logic                    fcs_load,
    output eth_tx_pkg::tx_lane_t    tx
);

    eth_tx_pkg::crc_t  fcs_value;
    eth_tx_pkg::byte_t wire_byte;

    // Checksum is only valid for one cycle at the generator
    always_ff @(posedge clock) begin
        if (fcs_load) begin
            fcs_value <= checksum;
        end
    end

    always_comb begin
        case (command.source)
            eth_tx_pkg::tx_preamble: wire_byte = eth_tx_pkg::PREAMBLE_BYTE;
            eth_tx_pkg::tx_sfd:      wire_byte = eth_tx_pkg::SFD_BYTE;
            eth_tx_pkg::tx_payload:  wire_byte = payload_byte;
            // Index 0 is the top byte, first out
            eth_tx_pkg::tx_fcs:      wire_byte = fcs_value[31 - 8 * command.fcs_index -: 8];
            default:                 wire_byte = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            tx <= '0;
        end else begin
            tx.data   <= wire_byte;
            tx.enable <= command.source != eth_tx_pkg::tx_idle;
        end
    end

endmodule

/* logic/eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top #(
    parameter int BUFFER_DEPTH = 2048
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  eth_tx_pkg::byte_t    data,
    input  logic                 data_enable,
    input  logic                 data_last,
    output logic                 ready,
    output eth_tx_pkg::tx_lane_t tx
);

    logic                    write_enable;
    logic                    frame_start;
    logic                    read_enable;
    eth_tx_pkg::byte_t       payload_byte;
    eth_tx_pkg::byte_t       crc_data;
    logic                    crc_enable;
    logic                    crc_last;
    eth_tx_pkg::crc_t        checksum;
    logic                    checksum_valid;
    logic                    fcs_load;
    eth_tx_pkg::tx_command_t command;

    eth_tx_control #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_eth_tx_control (
        .clock          (clock),
        .reset_n        (reset_n),
        .data           (data),
        .data_enable    (data_enable),
        .data_last      (data_last),
        .ready          (ready),
        .write_enable   (write_enable),
        .frame_start    (frame_start),
        .read_enable    (read_enable),
        .crc_data       (crc_data),
        .crc_enable     (crc_enable),
        .crc_last       (crc_last),
        .checksum_valid (checksum_valid),
        .fcs_load       (fcs_load),
        .command        (command)
    );

    eth_tx_frame_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_eth_tx_frame_buffer (
        .clock        (clock),
        .reset_n      (reset_n),
        .frame_start  (frame_start),
        .write_enable (write_enable),
        .write_data   (data),
        .read_enable  (read_enable),
        .read_data    (payload_byte)
    );

    // Generator busy flag is not needed, control owns the sequencing
    frame_check_sequence_generator i_frame_check_sequence_generator (
        .clock          (clock),
        .reset_n        (reset_n),
        .data           (crc_data),
        .data_enable    (crc_enable),
        .data_last      (crc_last),
        .ready          (),
        .checksum_valid (checksum_valid),
        .checksum       (checksum)
    );

    eth_tx_output_stage i_eth_tx_output_stage (
        .clock        (clock),
        .reset_n      (reset_n),
        .command      (command),
        .payload_byte (payload_byte),
        .checksum     (checksum),
        .fcs_load     (fcs_load),
        .tx           (tx)
    );

endmodule

/* tb/eth_tx_reference.svh */
`ifndef ETH_TX_REFERENCE_SVH
`define ETH_TX_REFERENCE_SVH

////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////

// 16-bit Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] galois_step(input logic [15:0] state);
    logic [15:0] result;
    result = state >> 1;
    if (state[0]) begin
        result = result ^ 16'hB400;
    end
    return result;
endfunction

////////////////////////////////////////////////////////////////////////
// Reference CRC-32
////////////////////////////////////////////////////////////////////////

// Reflected form, least significant bit of the octet first
function automatic logic [31:0] crc32_update(
    input logic [31:0] crc,
    input logic [7:0]  octet
);
    logic [31:0] result;
    result = crc ^ {24'h000000, octet};
    for (int i = 0; i < 8; i++) begin
        if (result[0]) begin
            result = (result >> 1) ^ 32'hEDB8_8320;
        end else begin
            result = result >> 1;
        end
    end
    return result;
endfunction

`endif

/* tb/eth_tx_tb.sv */
`timescale 1ns/1ps

module eth_tx_tb;

    localparam logic [7:0] PREAMBLE_VALUE = 8'h55;
    localparam logic [7:0] SFD_VALUE      = 8'hD5;
    localparam int PREAMBLE_LENGTH = 7;
    localparam int MIN_FRAME_BYTES = 60;
    localparam int FCS_LENGTH      = 4;
    localparam int GAP_LENGTH      = 12;

    localparam int SHORT_LENGTH  = 14;
    localparam int MIN_LENGTH    = 60;
    localparam int LONG_LENGTH   = 300;
    localparam int FIRST_LENGTH  = 100;
    localparam int SECOND_LENGTH = 20;
    localparam int TINY_LENGTH   = 1;

    logic                 clock;
    logic                 reset_n;
    eth_tx_pkg::byte_t    data;
    logic                 data_enable;
    logic                 data_last;
    logic                 ready;
    eth_tx_pkg::tx_lane_t tx;

    eth_tx_pkg::byte_t payload[$];
    eth_tx_pkg::byte_t expected[$];
    eth_tx_pkg::byte_t captured[$];
    eth_tx_pkg::byte_t first_payload[$];
    eth_tx_pkg::byte_t second_payload[$];
    eth_tx_pkg::byte_t first_expected[$];
    eth_tx_pkg::byte_t first_captured[$];

    logic [15:0] lfsr_state = 16'd18;
    int cycle_count = 0;
    int timeout_limit = 0;
    int check_count = 0;
    int error_count = 0;
    int busy_samples;
    int ready_rise_cycle;
    int enable_fall_cycle;

    `include "eth_tx_reference.svh"

    eth_tx_top i_eth_tx_top (
        .clock       (clock),
        .reset_n     (reset_n),
        .data        (data),
        .data_enable (data_enable),
        .data_last   (data_last),
        .ready       (ready),
        .tx          (tx)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    function automatic int wire_length(input int length);
        int body;
        body = (length < MIN_FRAME_BYTES) ? MIN_FRAME_BYTES : length;
        return PREAMBLE_LENGTH + 1 + body + FCS_LENGTH;
    endfunction

    task automatic check_equal(
        input logic [31:0] actual,
        input logic [31:0] expected_value,
        input string       what
    );
        check_count++;
        if (actual !== expected_value) begin
            error_count++;
            $display("Fail at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected_value);
        end
    endtask

    task automatic next_random_byte(output eth_tx_pkg::byte_t value);
        value = '0;
        // One LFSR step per bit
        for (int i = 0; i < 8; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic build_random_payload(input int length);
        eth_tx_pkg::byte_t value;
        payload.delete();
        for (int i = 0; i < length; i++) begin
            next_random_byte(value);
            payload.push_back(value);
        end
    endtask

    // Preamble, SFD, payload and zero pad, then the FCS low byte first
    task automatic build_expected();
        logic [31:0]       crc;
        eth_tx_pkg::byte_t octet;
        int                padded;
        expected.delete();
        crc    = 32'hFFFF_FFFF;
        padded = (payload.size() < MIN_FRAME_BYTES) ? MIN_FRAME_BYTES : payload.size();
        repeat (PREAMBLE_LENGTH) expected.push_back(PREAMBLE_VALUE);
        expected.push_back(SFD_VALUE);
        for (int i = 0; i < padded; i++) begin
            octet = (i < payload.size()) ? payload[i] : 8'h00;
            crc   = crc32_update(crc, octet);
            expected.push_back(octet);
        end
        crc = ~crc;
        for (int i = 0; i < FCS_LENGTH; i++) begin
            expected.push_back(crc[8 * i +: 8]);
        end
    endtask

    // Junk bytes with data_last go out while ready is low if asked to
    task automatic send_frame(input bit offer_while_busy);
        busy_samples = 0;
        for (int i = 0; i < payload.size(); i++) begin
            @(negedge clock);
            while (!ready) begin
                busy_samples++;
                data        = offer_while_busy ? 8'h3C : 8'h00;
                data_enable = offer_while_busy;
                data_last   = offer_while_busy;
                @(negedge clock);
            end
            if (i == 0) begin
                ready_rise_cycle = cycle_count;
            end
            data        = payload[i];
            data_enable = 1'b1;
            data_last   = (i == payload.size() - 1);
        end
    endtask

    task automatic release_inputs();
        @(negedge clock);
        data        = '0;
        data_enable = 1'b0;
        data_last   = 1'b0;
    endtask

    task automatic capture_frame();
        captured.delete();
        @(negedge clock);
        while (!tx.enable) begin
            @(negedge clock);
        end
        while (tx.enable) begin
            captured.push_back(tx.data);
            @(negedge clock);
        end
        enable_fall_cycle = cycle_count;
    endtask

    task automatic compare_frame(input int length);
        int count;
        check_equal(captured.size(), wire_length(length), "enable cycles");
        count = (captured.size() < expected.size()) ? captured.size() : expected.size();
        for (int i = 0; i < count; i++) begin
            check_equal(captured[i], expected[i], $sformatf("wire byte %0d", i));
        end
    endtask

    task automatic run_single_frame(input int length);
        build_random_payload(length);
        build_expected();
        fork
            begin
                send_frame(1'b0);
                release_inputs();
            end
            capture_frame();
        join
        compare_frame(length);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("%s finished with %0d errors", name, error_count - errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clock);
        check_equal(ready, 1'b1, "ready after reset");
        check_equal(tx.enable, 1'b0, "tx.enable after reset");
        check_equal(tx.data, 8'h00, "tx.data after reset");
        finish_test("reset state", errors_before);
    endtask

    task automatic test_frame(input string name, input int length);
        int errors_before;
        errors_before = error_count;
        run_single_frame(length);
        finish_test(name, errors_before);
    endtask

    task automatic test_back_to_back();
        int errors_before;
        int first_fall_cycle;
        errors_before = error_count;
        build_random_payload(FIRST_LENGTH);
        build_expected();
        first_payload  = payload;
        first_expected = expected;
        build_random_payload(SECOND_LENGTH);
        build_expected();
        second_payload = payload;
        fork
            begin
                payload = first_payload;
                send_frame(1'b0);
                payload = second_payload;
                send_frame(1'b1);
                release_inputs();
            end
            begin
                capture_frame();
                first_captured   = captured;
                first_fall_cycle = enable_fall_cycle;
                capture_frame();
            end
        join
        check_equal(busy_samples > 0, 1'b1, "ready low after data_last");
        check_equal(ready_rise_cycle - first_fall_cycle, GAP_LENGTH, "ready gap cycles");
        compare_frame(SECOND_LENGTH);
        expected = first_expected;
        captured = first_captured;
        compare_frame(FIRST_LENGTH);
        finish_test("back to back", errors_before);
    endtask

    initial begin
        reset_n     = 1'b0;
        data        = '0;
        data_enable = 1'b0;
        data_last   = 1'b0;
        // Twice the frame and gap cycles of all tests
        timeout_limit = 2 * (wire_length(SHORT_LENGTH) + wire_length(MIN_LENGTH)
                        + wire_length(LONG_LENGTH) + wire_length(FIRST_LENGTH)
                        + wire_length(SECOND_LENGTH) + wire_length(TINY_LENGTH)
                        + 6 * GAP_LENGTH) + 200;
        repeat (16) @(negedge clock);
        reset_n = 1'b1;

        test_reset_state();
        test_frame("short frame", SHORT_LENGTH);
        test_frame("minimum frame", MIN_LENGTH);
        test_frame("long frame", LONG_LENGTH);
        test_back_to_back();
        test_frame("single byte frame", TINY_LENGTH);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+tb
logic/eth_tx_pkg.sv
logic/frame_check_sequence_generator.sv
logic/eth_tx_control.sv
logic/eth_tx_frame_buffer.sv
logic/eth_tx_output_stage.sv
logic/eth_tx_top.sv
tb/eth_tx_tb.sv

/* Bender.yml */
package:
  name: eth_tx

sources:
  - files:
      - logic/eth_tx_pkg.sv
      - logic/frame_check_sequence_generator.sv
      - logic/eth_tx_control.sv
      - logic/eth_tx_frame_buffer.sv
      - logic/eth_tx_output_stage.sv
      - logic/eth_tx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/eth_tx_tb.sv
